// ==== chain_fir.sv ====
module chain_fir (
    input  logic                     aclk,
    input  logic                     arst_n_i,
    input  trigger_pkg::wb_loc_req_t req_i,
    output trigger_pkg::wb_rsp_t     rsp_o,
    input  trigger_pkg::samp_vec_t   dat_i,
    output trigger_pkg::mid_vec_t    dat_o
);
    import trigger_pkg::*;

    // c * x is COEF_W + NBITS wide, one extra bit for the sum of two taps
    localparam int ACC_W = COEF_W + NBITS + 1;
    localparam logic signed [ACC_W-1:0] MID_MAX = (2 ** (MID_BITS - 1)) - 1;
    localparam logic signed [ACC_W-1:0] MID_MIN = -(2 ** (MID_BITS - 1));

    reg_op_e                  op;
    logic                     ack_q;
    logic                     err_q;
    logic [WB_DAT_W-1:0]      rdat_q;
    logic signed [COEF_W-1:0] c0_q;
    logic signed [COEF_W-1:0] c1_q;
    samp_t                    hist_q;
    mid_vec_t                 fir_d;
    mid_vec_t                 dat_q;

    // clamp the shifted sum into the 16 bit mid sample
    function automatic mid_t sat_mid(input logic signed [ACC_W-1:0] v);
        if (v > MID_MAX) begin
            return MID_MAX[MID_BITS-1:0];
        end else if (v < MID_MIN) begin
            return MID_MIN[MID_BITS-1:0];
        end
        return v[MID_BITS-1:0];
    endfunction

    // two taps across the beat, ext[0] is last sample of the prior beat
    always_comb begin : fir_calc
        samp_t [NSAMP:0]         ext;
        logic signed [ACC_W-1:0] acc;
        ext = {dat_i, hist_q};
        for (int k = 0; k < NSAMP; k++) begin
            acc      = c0_q * ext[k+1] + c1_q * ext[k];
            fir_d[k] = sat_mid(acc >>> FIR_SHIFT);
        end
    end

    // sample history and output register
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q <= '0;
            dat_q  <= '0;
        end else begin
            hist_q <= dat_i[NSAMP-1];
            dat_q  <= fir_d;
        end
    end

    assign dat_o = dat_q;

    // classify the access, nothing new while a response is on the bus
    always_comb begin
        op = REG_IDLE;
        if (req_i.cyc && req_i.stb && !ack_q && !err_q) begin
            if (req_i.adr != FIR_C0_ADR && req_i.adr != FIR_C1_ADR) begin
                op = REG_BAD;
            end else if (req_i.we) begin
                op = REG_WRITE;
            end else begin
                op = REG_READ;
            end
        end
    end

    // coefficient registers and one cycle response
    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            rdat_q <= '0;
            c0_q   <= FIR_C0_DEF;
            c1_q   <= FIR_C1_DEF;
        end else begin
            ack_q <= (op == REG_READ) || (op == REG_WRITE);
            err_q <= (op == REG_BAD);
            if (op == REG_WRITE) begin
                if (req_i.adr == FIR_C0_ADR) begin
                    c0_q <= req_i.dat[COEF_W-1:0];
                end else begin
                    c1_q <= req_i.dat[COEF_W-1:0];
                end
            end
            // coefficients read back sign extended
            if (op == REG_READ) begin
                if (req_i.adr == FIR_C0_ADR) begin
                    rdat_q <= {{(WB_DAT_W - COEF_W){c0_q[COEF_W-1]}}, c0_q};
                end else begin
                    rdat_q <= {{(WB_DAT_W - COEF_W){c1_q[COEF_W-1]}}, c1_q};
                end
            end
        end
    end

    assign rsp_o = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

// ==== chain_gain.sv ====
module chain_gain (
    input  logic                     aclk,
    input  logic                     arst_n_i,
    input  trigger_pkg::wb_loc_req_t req_i,
    output trigger_pkg::wb_rsp_t     rsp_o,
    input  trigger_pkg::mid_vec_t    dat_i,
    output trigger_pkg::out_vec_t    dat_o
);
    import trigger_pkg::*;

    // offset subtraction grows one bit, unsigned scale adds SCL_W + 1
    localparam int DIFF_W = MID_BITS + 1;
    localparam int PROD_W = DIFF_W + SCL_W + 1;
    localparam int CNT_W  = $clog2(NSAMP + 1);
    localparam logic signed [PROD_W-1:0] OUT_MAX = (2 ** (OUTBITS - 1)) - 1;
    localparam logic signed [PROD_W-1:0] OUT_MIN = -(2 ** (OUTBITS - 1));

    reg_op_e                    op;
    logic                       ack_q;
    logic                       err_q;
    logic [WB_DAT_W-1:0]        rdat_q;
    logic signed [MID_BITS-1:0] ofs_q;
    logic [SCL_W-1:0]           scl_q;
    logic [WB_DAT_W-1:0]        clip_q;
    logic [WB_DAT_W-1:0]        clip_next;
    logic [CNT_W-1:0]           nclip;
    out_vec_t                   gain_d;
    out_vec_t                   dat_q;

    // requantize every sample and count the ones that hit a rail
    always_comb begin : gain_calc
        logic signed [DIFF_W-1:0] diff;
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] shifted;
        nclip = '0;
        for (int k = 0; k < NSAMP; k++) begin
            diff    = dat_i[k] - ofs_q;
            prod    = diff * $signed({1'b0, scl_q});
            shifted = prod >>> GAIN_SHIFT;
            if (shifted > OUT_MAX) begin
                gain_d[k] = OUT_MAX[OUTBITS-1:0];
                nclip     = nclip + 1'b1;
            end else if (shifted < OUT_MIN) begin
                gain_d[k] = OUT_MIN[OUTBITS-1:0];
                nclip     = nclip + 1'b1;
            end else begin
                gain_d[k] = shifted[OUTBITS-1:0];
            end
        end
    end

    // clip counter sticks at all ones instead of wrapping
    always_comb begin : clip_calc
        logic [WB_DAT_W:0] sum;
        sum       = {1'b0, clip_q} + (WB_DAT_W + 1)'(nclip);
        clip_next = sum[WB_DAT_W] ? '1 : sum[WB_DAT_W-1:0];
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dat_q <= '0;
        end else begin
            dat_q <= gain_d;
        end
    end

    assign dat_o = dat_q;

    // decode access kind, writes to the clip counter are rejected
    always_comb begin
        op = REG_IDLE;
        if (req_i.cyc && req_i.stb && !ack_q && !err_q) begin
            if (req_i.adr != GAIN_OFS_ADR && req_i.adr != GAIN_SCL_ADR &&
                req_i.adr != GAIN_CLIP_ADR) begin
                op = REG_BAD;
            end else if (req_i.we && req_i.adr == GAIN_CLIP_ADR) begin
                op = REG_BAD;
            end else if (req_i.we) begin
                op = REG_WRITE;
            end else begin
                op = REG_READ;
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            rdat_q <= '0;
            ofs_q  <= GAIN_OFS_DEF;
            scl_q  <= GAIN_SCL_DEF;
            clip_q <= '0;
        end else begin
            ack_q <= (op == REG_READ) || (op == REG_WRITE);
            err_q <= (op == REG_BAD);
            if (op == REG_WRITE) begin
                if (req_i.adr == GAIN_OFS_ADR) begin
                    ofs_q <= req_i.dat[MID_BITS-1:0];
                end else begin
                    scl_q <= req_i.dat[SCL_W-1:0];
                end
            end
            // read of the counter clears it, clips of this beat are kept
            if (op == REG_READ && req_i.adr == GAIN_CLIP_ADR) begin
                clip_q <= WB_DAT_W'(nclip);
            end else begin
                clip_q <= clip_next;
            end
            if (op == REG_READ) begin
                case (req_i.adr)
                    GAIN_OFS_ADR: rdat_q <= {{(WB_DAT_W - MID_BITS){ofs_q[MID_BITS-1]}}, ofs_q};
                    GAIN_SCL_ADR: rdat_q <= {{(WB_DAT_W - SCL_W){1'b0}}, scl_q};
                    default:      rdat_q <= clip_q;
                endcase
            end
        end
    end

    assign rsp_o = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

// ==== project.f ====
trigger_pkg.sv
wb_chan_decoder.sv
chain_fir.sv
chain_gain.sv
trigger_chain.sv
trigger_chain_x8.sv
tb_trigger_chain_x8.sv

// ==== tb_trigger_chain_x8.sv ====
module tb_trigger_chain_x8;
    import trigger_pkg::*;

    logic      aclk;
    logic      arst_n_i;
    wb_req_t   fir_req;
    wb_rsp_t   fir_rsp;
    wb_req_t   gain_req;
    wb_rsp_t   gain_rsp;
    chan_in_t  dat_i;
    chan_out_t dat_o;

    // per channel shadows of the DUT registers and stream state
    int        c0_m [NCHAN];
    int        c1_m [NCHAN];
    int        ofs_m [NCHAN];
    int        scl_m [NCHAN];
    int        hist_m [NCHAN];
    int        clip_m [NCHAN];
    logic [31:0] rng_state;
    chan_out_t exp_q [$];
    // name of the running test for error lines
    string     test_name;

    trigger_chain_x8 trigger_chain_x8_inst (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .wb_fir_req_i  (fir_req),
        .wb_fir_rsp_o  (fir_rsp),
        .wb_gain_req_i (gain_req),
        .wb_gain_rsp_o (gain_rsp),
        .dat_i         (dat_i),
        .dat_o         (dat_o)
    );

    always #2 aclk = ~aclk;

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            report_fail($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                  test_name, name, exp, act));
        end
    endtask

    task automatic check_vec(input string name, input chan_out_t exp, input chan_out_t act);
        assert (exp === act) else begin
            report_fail($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                  test_name, name, exp, act));
        end
    endtask

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v > hi) return hi;
        if (v < lo) return lo;
        return v;
    endfunction

    // fir then gain for one channel
    // nclip returns the number of samples that hit a rail
    function automatic out_vec_t model_chan(input int ch, input samp_vec_t x, output int nclip);
        out_vec_t o;
        int cur;
        int prev;
        int mid;
        int q;
        nclip = 0;
        for (int k = 0; k < NSAMP; k++) begin
            cur  = $signed(x[k]);
            prev = (k == 0) ? hist_m[ch] : $signed(x[k-1]);
            mid  = clamp((c0_m[ch] * cur + c1_m[ch] * prev) >>> FIR_SHIFT, -32768, 32767);
            q    = ((mid - ofs_m[ch]) * scl_m[ch]) >>> GAIN_SHIFT;
            if (q > 15 || q < -16) nclip++;
            o[k] = out_t'(clamp(q, -16, 15));
        end
        return o;
    endfunction

    // queues the expected result and drives the beat on a rising edge
    task automatic apply_beat(input chan_in_t b);
        chan_out_t e;
        int nc;
        for (int ch = 0; ch < NCHAN; ch++) begin
            e[ch]       = model_chan(ch, b[ch], nc);
            clip_m[ch] += nc;
            hist_m[ch]  = $signed(b[ch][NSAMP-1]);
        end
        exp_q.push_back(e);
        dat_i <= b;
    endtask

    // two drain beats of a fixed value close the stream
    task automatic stream_beats(input string name, input int n, input int drain);
        chan_in_t b;
        for (int i = 0; i < n + 2; i++) begin
            @(posedge aclk);
            for (int ch = 0; ch < NCHAN; ch++) begin
                for (int k = 0; k < NSAMP; k++) begin
                    b[ch][k] = (i < n) ? samp_t'(xorshift()) : samp_t'(drain);
                end
            end
            apply_beat(b);
            @(negedge aclk);
            if (exp_q.size() == 3) check_vec(name, exp_q.pop_front(), dat_o);
        end
        exp_q.delete();
    endtask

    // port 0 selects the fir bus and port 1 the gain bus
    // lat counts negedges until the response
    task automatic bus_access(input int port, input int ch, input logic [7:0] adr,
                              input logic we, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic ack, output logic err,
                              output int lat);
        wb_req_t r;
        wb_rsp_t s;
        r     = '0;
        r.cyc = 1'b1;
        r.stb = 1'b1;
        r.we  = we;
        r.sel = 4'hf;
        r.adr = (WB_ADR_W'(ch) << CHAN_LSB) | WB_ADR_W'(adr);
        r.dat = wdat;
        lat   = 0;
        @(posedge aclk);
        if (port == 0) fir_req <= r;
        else gain_req <= r;
        do begin
            @(negedge aclk);
            lat++;
            s = (port == 0) ? fir_rsp : gain_rsp;
            if (lat > 16) report_fail("bus transfer got neither ack nor err");
        end while (!s.ack && !s.err);
        rdat = s.dat;
        ack  = s.ack;
        err  = s.err;
        @(posedge aclk);
        if (port == 0) fir_req <= '0;
        else gain_req <= '0;
    endtask

    task automatic bus_write(input int port, input int ch, input logic [7:0] adr,
                             input logic [31:0] wdat);
        logic [31:0] rd;
        logic ack;
        logic err;
        int lat;
        bus_access(port, ch, adr, 1'b1, wdat, rd, ack, err, lat);
        check_val("bus_write ack", 32'd1, {31'd0, ack});
    endtask

    task automatic bus_read(input int port, input int ch, input logic [7:0] adr,
                            output logic [31:0] rd);
        logic ack;
        logic err;
        int lat;
        bus_access(port, ch, adr, 1'b0, '0, rd, ack, err, lat);
        check_val("bus_read ack", 32'd1, {31'd0, ack});
    endtask

    task automatic test_reset_defaults();
        logic [31:0] rd;
        test_name = "test_reset_defaults";
        for (int ch = 0; ch < NCHAN; ch++) begin
            bus_read(0, ch, FIR_C0_ADR, rd);
            check_val("reset c0", 32'd64, rd);
            bus_read(0, ch, FIR_C1_ADR, rd);
            check_val("reset c1", 32'd0, rd);
            bus_read(1, ch, GAIN_OFS_ADR, rd);
            check_val("reset ofs", 32'd0, rd);
            bus_read(1, ch, GAIN_SCL_ADR, rd);
            check_val("reset scl", 32'd16, rd);
            bus_read(1, ch, GAIN_CLIP_ADR, rd);
            check_val("reset clip", 32'd0, rd);
        end
        stream_beats("dat_o", 40, 0);
    endtask

    task automatic test_reg_isolation();
        logic [31:0] rd;
        logic ack;
        logic err;
        int lat;
        test_name = "test_reg_isolation";
        bus_access(0, 3, FIR_C0_ADR, 1'b1, 32'hffff_ffe9, rd, ack, err, lat);
        // first negedge lies in the request cycle and ack shows on the second
        check_val("write latency", 32'd2, lat);
        c0_m[3] = -23;
        bus_write(0, 3, FIR_C1_ADR, 32'd37);
        c1_m[3] = 37;
        for (int ch = 0; ch < NCHAN; ch++) begin
            bus_access(0, ch, FIR_C0_ADR, 1'b0, '0, rd, ack, err, lat);
            check_val("read latency", 32'd2, lat);
            check_val("c0", 32'(c0_m[ch]), rd);
            bus_read(0, ch, FIR_C1_ADR, rd);
            check_val("c1", 32'(c1_m[ch]), rd);
        end
    endtask

    task automatic test_bad_access();
        logic [31:0] rd;
        logic ack;
        logic err;
        int lat;
        test_name = "test_bad_access";
        bus_access(0, 5, 8'h10, 1'b0, '0, rd, ack, err, lat);
        check_val("read err", 32'd1, {31'd0, err});
        check_val("read ack", 32'd0, {31'd0, ack});
        bus_access(1, 2, GAIN_CLIP_ADR, 1'b1, 32'h1234_5678, rd, ack, err, lat);
        check_val("clip write err", 32'd1, {31'd0, err});
        check_val("clip write ack", 32'd0, {31'd0, ack});
        bus_read(0, 5, FIR_C0_ADR, rd);
        check_val("c0", 32'(c0_m[5]), rd);
        bus_read(1, 2, GAIN_OFS_ADR, rd);
        check_val("ofs", 32'(ofs_m[2]), rd);
        bus_read(1, 2, GAIN_SCL_ADR, rd);
        check_val("scl", 32'(scl_m[2]), rd);
        // rejected write must leave the count of the earlier stream in place
        bus_read(1, 2, GAIN_CLIP_ADR, rd);
        check_val("clip", 32'(clip_m[2]), rd);
        clip_m[2] = 0;
    endtask

    task automatic test_fir_stream();
        test_name = "test_fir_stream";
        for (int ch = 0; ch < NCHAN; ch++) begin
            c0_m[ch] = $signed(xorshift() & 32'hff) - 128;
            c1_m[ch] = $signed(xorshift() & 32'hff) - 128;
            bus_write(0, ch, FIR_C0_ADR, 32'(c0_m[ch]));
            bus_write(0, ch, FIR_C1_ADR, 32'(c1_m[ch]));
            // small scale keeps most outputs off the rails
            scl_m[ch] = 1;
            bus_write(1, ch, GAIN_SCL_ADR, 32'd1);
        end
        stream_beats("dat_o", 200, 0);
    endtask

    task automatic test_clip_count();
        chan_in_t    b;
        logic [31:0] rd;
        test_name = "test_clip_count";
        // neutral beat equals the offset and never clips
        for (int ch = 0; ch < NCHAN; ch++) begin
            for (int k = 0; k < NSAMP; k++) b[ch][k] = samp_t'(100);
        end
        @(posedge aclk);
        apply_beat(b);
        exp_q.delete();
        for (int ch = 0; ch < NCHAN; ch++) begin
            c0_m[ch]  = 64;
            c1_m[ch]  = 0;
            ofs_m[ch] = 100;
            scl_m[ch] = 200;
            bus_write(0, ch, FIR_C0_ADR, 32'd64);
            bus_write(0, ch, FIR_C1_ADR, 32'd0);
            bus_write(1, ch, GAIN_OFS_ADR, 32'd100);
            bus_write(1, ch, GAIN_SCL_ADR, 32'd200);
            bus_read(1, ch, GAIN_CLIP_ADR, rd);
            clip_m[ch] = 0;
        end
        stream_beats("dat_o", 60, 100);
        for (int ch = 0; ch < NCHAN; ch++) begin
            bus_read(1, ch, GAIN_CLIP_ADR, rd);
            check_val("first read", 32'(clip_m[ch]), rd);
            bus_read(1, ch, GAIN_CLIP_ADR, rd);
            check_val("second read", 32'd0, rd);
        end
    endtask

    // bound far above the total length of all tests
    initial begin
        repeat (20000) @(posedge aclk);
        report_fail("watchdog timeout, simulation did not finish");
    end

    initial begin
        aclk      = 1'b0;
        arst_n_i  = 1'b0;
        fir_req   = '0;
        gain_req  = '0;
        dat_i     = '0;
        rng_state = 32'h4dfa_f6e2;
        for (int ch = 0; ch < NCHAN; ch++) begin
            c0_m[ch]   = 64;
            c1_m[ch]   = 0;
            ofs_m[ch]  = 0;
            scl_m[ch]  = 16;
            hist_m[ch] = 0;
            clip_m[ch] = 0;
        end
        repeat (10) @(posedge aclk);
        arst_n_i <= 1'b1;
        test_reset_defaults();
        test_reg_isolation();
        test_bad_access();
        test_fir_stream();
        test_clip_count();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== trigger_chain.sv ====
module trigger_chain (
    input  logic                     aclk,
    input  logic                     arst_n_i,
    input  trigger_pkg::wb_loc_req_t fir_req_i,
    output trigger_pkg::wb_rsp_t     fir_rsp_o,
    input  trigger_pkg::wb_loc_req_t gain_req_i,
    output trigger_pkg::wb_rsp_t     gain_rsp_o,
    input  trigger_pkg::samp_vec_t   dat_i,
    output trigger_pkg::out_vec_t    dat_o
);
    import trigger_pkg::*;

    // filtered beat, one cycle behind dat_i
    mid_vec_t mid;

    // stage 1: two tap fir
    chain_fir chain_fir_inst (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .req_i    (fir_req_i),
        .rsp_o    (fir_rsp_o),
        .dat_i    (dat_i),
        .dat_o    (mid)
    );

    // stage 2: offset, gain and 5 bit requantize
    chain_gain chain_gain_inst (
        .aclk     (aclk),
        .arst_n_i (arst_n_i),
        .req_i    (gain_req_i),
        .rsp_o    (gain_rsp_o),
        .dat_i    (mid),
        .dat_o    (dat_o)
    );

endmodule

// ==== trigger_chain_x8.sv ====
module trigger_chain_x8 (
    input  logic                  aclk,
    input  logic                  arst_n_i,
    input  trigger_pkg::wb_req_t  wb_fir_req_i,
    output trigger_pkg::wb_rsp_t  wb_fir_rsp_o,
    input  trigger_pkg::wb_req_t  wb_gain_req_i,
    output trigger_pkg::wb_rsp_t  wb_gain_rsp_o,
    input  trigger_pkg::chan_in_t dat_i,
    output trigger_pkg::chan_out_t dat_o
);
    import trigger_pkg::*;

    // per channel local buses
    wb_loc_req_t [NCHAN-1:0] fir_req;
    wb_rsp_t     [NCHAN-1:0] fir_rsp;
    wb_loc_req_t [NCHAN-1:0] gain_req;
    wb_rsp_t     [NCHAN-1:0] gain_rsp;

    // coefficient bus
    wb_chan_decoder fir_decoder_inst (
        .aclk      (aclk),
        .req_i     (wb_fir_req_i),
        .rsp_o     (wb_fir_rsp_o),
        .loc_req_o (fir_req),
        .loc_rsp_i (fir_rsp)
    );

    // offset / scale / clip counter bus
    wb_chan_decoder gain_decoder_inst (
        .aclk      (aclk),
        .req_i     (wb_gain_req_i),
        .rsp_o     (wb_gain_rsp_o),
        .loc_req_o (gain_req),
        .loc_rsp_i (gain_rsp)
    );

    // one independent chain per channel
    for (genvar n = 0; n < NCHAN; n++) begin : g_chain
        trigger_chain trigger_chain_inst (
            .aclk       (aclk),
            .arst_n_i   (arst_n_i),
            .fir_req_i  (fir_req[n]),
            .fir_rsp_o  (fir_rsp[n]),
            .gain_req_i (gain_req[n]),
            .gain_rsp_o (gain_rsp[n]),
            .dat_i      (dat_i[n]),
            .dat_o      (dat_o[n])
        );
    end

endmodule

// ==== trigger_pkg.sv ====
package trigger_pkg;

    // channel and stream geometry
    localparam int NCHAN   = 8;
    localparam int NSAMP   = 4;
    localparam int NBITS   = 12;
    localparam int OUTBITS = 5;

    // wishbone widths, channel select lives in adr[12:10]
    localparam int WB_ADR_W  = 22;
    localparam int WB_DAT_W  = 32;
    localparam int LOC_ADR_W = 8;
    localparam int CHAN_LSB  = 10;
    localparam int CHAN_W    = $clog2(NCHAN);

    // datapath scaling
    localparam int FIR_SHIFT  = 6;
    localparam int GAIN_SHIFT = 8;
    localparam int MID_BITS   = 16;
    localparam int COEF_W     = 8;
    localparam int SCL_W      = 8;

    // fir register map, defaults give unity passthrough (64 >> 6)
    localparam logic [LOC_ADR_W-1:0] FIR_C0_ADR = 8'h00;
    localparam logic [LOC_ADR_W-1:0] FIR_C1_ADR = 8'h04;
    localparam logic signed [COEF_W-1:0] FIR_C0_DEF = 8'sd64;
    localparam logic signed [COEF_W-1:0] FIR_C1_DEF = 8'sd0;

    // gain register map, clip counter is read only
    localparam logic [LOC_ADR_W-1:0] GAIN_OFS_ADR  = 8'h00;
    localparam logic [LOC_ADR_W-1:0] GAIN_SCL_ADR  = 8'h04;
    localparam logic [LOC_ADR_W-1:0] GAIN_CLIP_ADR = 8'h08;
    localparam logic signed [MID_BITS-1:0] GAIN_OFS_DEF = 16'sd0;
    localparam logic [SCL_W-1:0] GAIN_SCL_DEF = 8'd16;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [3:0]          sel;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [3:0]           sel;
        logic [LOC_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0]  dat;
    } wb_loc_req_t;

    typedef struct packed {
        logic                ack;
        logic                err;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // named signed element types keep array elements signed
    typedef logic signed [NBITS-1:0]    samp_t;
    typedef logic signed [MID_BITS-1:0] mid_t;
    typedef logic signed [OUTBITS-1:0]  out_t;

    typedef samp_t [NSAMP-1:0] samp_vec_t;
    typedef mid_t  [NSAMP-1:0] mid_vec_t;
    typedef out_t  [NSAMP-1:0] out_vec_t;

    typedef samp_vec_t [NCHAN-1:0] chan_in_t;
    typedef out_vec_t  [NCHAN-1:0] chan_out_t;

    typedef enum logic [1:0] {
        REG_IDLE,
        REG_READ,
        REG_WRITE,
        REG_BAD
    } reg_op_e;

endpackage

// ==== wb_chan_decoder.sv ====
module wb_chan_decoder (
    input  logic                                              aclk,
    input  trigger_pkg::wb_req_t                              req_i,
    output trigger_pkg::wb_rsp_t                              rsp_o,
    output trigger_pkg::wb_loc_req_t [trigger_pkg::NCHAN-1:0] loc_req_o,
    input  trigger_pkg::wb_rsp_t     [trigger_pkg::NCHAN-1:0] loc_rsp_i
);
    import trigger_pkg::*;

    // purely combinational, aclk is not used here
    logic [CHAN_W-1:0] chan_sel;

    // channel number from adr[12:10], everything else above bit 7 ignored
    assign chan_sel = req_i.adr[CHAN_LSB +: CHAN_W];

    // fan out the request to all channels
    always_comb begin
        for (int n = 0; n < NCHAN; n++) begin
            // only the addressed channel sees cyc
            loc_req_o[n].cyc = req_i.cyc && (chan_sel == CHAN_W'(n));
            loc_req_o[n].stb = req_i.stb;
            loc_req_o[n].we  = req_i.we;
            loc_req_o[n].sel = req_i.sel;
            // local register offset within the channel
            loc_req_o[n].adr = req_i.adr[LOC_ADR_W-1:0];
            loc_req_o[n].dat = req_i.dat;
        end
    end

    // return path follows the same select field
    // the other channels never respond since their cyc is low
    assign rsp_o = loc_rsp_i[chan_sel];

endmodule
